// File: hdl/core_pkg.sv
package core_pkg;

localparam int XLEN = 32;
localparam int NREGS = 16;
localparam int REG_W = $clog2(NREGS);

// Opcodes sit in the top four bits of every instruction word
typedef enum logic [3:0] {
	ADD  = 4'd0,
	SUB  = 4'd1,
	AND  = 4'd2,
	OR   = 4'd3,
	XOR  = 4'd4,
	SLL  = 4'd5,
	SRL  = 4'd6,
	ADDI = 4'd7,
	LDW  = 4'd8,
	STW  = 4'd9,
	BEQ  = 4'd10,
	BNE  = 4'd11,
	NOP  = 4'd12,
	HALT = 4'd13
} op_e;

// Register to register format
typedef struct packed {
	op_e              opcode;
	logic [REG_W-1:0] rd;
	logic [REG_W-1:0] ra;
	logic [REG_W-1:0] rb;
	logic [15:0]      unused;
} instr_r_t;

// Immediate format, also used by loads, stores and branches
typedef struct packed {
	op_e              opcode;
	logic [REG_W-1:0] rd;   // Data source for STW, compare operand for branches
	logic [REG_W-1:0] ra;
	logic [19:0]      imm20;
} instr_i_t;

typedef union packed {
	instr_r_t r;
	instr_i_t i;
} instr_t;

endpackage

// File: hdl/core_regfile.sv
`timescale 1ns/10ps

module core_regfile import core_pkg::*; (
	input  logic             clk,
	input  logic             i_arst_n,
	input  logic [REG_W-1:0] i_ra_sel,
	input  logic [REG_W-1:0] i_rb_sel,
	input  logic             i_wr_en,
	input  logic [REG_W-1:0] i_wr_sel,
	input  logic [XLEN-1:0]  i_wr_val,
	output logic [XLEN-1:0]  o_ra,
	output logic [XLEN-1:0]  o_rb
);

logic [XLEN-1:0] regs [NREGS];

always_ff @(posedge clk or negedge i_arst_n) begin
	if (!i_arst_n)
		regs <= '{default: '0};
	else if (i_wr_en && i_wr_sel != '0)
		regs[i_wr_sel] <= i_wr_val;
end

// Same-cycle writes are not bypassed here
assign o_ra = (i_ra_sel == '0) ? '0 : regs[i_ra_sel];
assign o_rb = (i_rb_sel == '0) ? '0 : regs[i_rb_sel];

endmodule

// File: hdl/core_fetch.sv
`timescale 1ns/10ps

module core_fetch import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            i_arst_n,
	input  logic            i_stall,
	input  logic            i_redirect,
	input  logic [XLEN-1:0] i_target,
	input  logic            i_halt_seen,
	input  logic            i_ready,
	input  logic            i_rvalid,
	input  logic [XLEN-1:0] i_rdata,
	output logic            o_req_valid,
	output logic [XLEN-3:0] o_addr,
	output instr_t          o_instr,
	output logic [XLEN-1:0] o_pc_next,
	output logic            o_valid,
	output logic            o_halted
);

logic [XLEN-1:0] pc_q;
logic            req_q;
logic            wait_q;
logic            drop_q;
logic            halt_q;
logic            issue;

// A new fetch starts only once the previous word has left the buffer
assign issue = !req_q && !wait_q && !o_valid && !halt_q && !i_redirect;
assign o_req_valid = req_q;

always_ff @(posedge clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		pc_q <= RESET_PC;
		req_q <= 1'b0;
		wait_q <= 1'b0;
		drop_q <= 1'b0;
		o_valid <= 1'b0;
		halt_q <= 1'b0;
		o_halted <= 1'b0;
	end else begin
		if (issue) begin
			req_q <= 1'b1;
			pc_q <= pc_q + XLEN'(4);
		end else if (req_q && i_ready) begin
			req_q <= 1'b0;
			wait_q <= 1'b1;
		end

		if (wait_q && i_rvalid) begin
			wait_q <= 1'b0;
			drop_q <= 1'b0;
			if (!drop_q && !i_redirect)
				o_valid <= 1'b1;
		end else if (o_valid && !i_stall) begin
			o_valid <= 1'b0;   // Decode took the word
		end

		// Anything still in flight on the bus belongs to the old path
		if (i_redirect) begin
			pc_q <= i_target;
			o_valid <= 1'b0;
			if (req_q || (wait_q && !i_rvalid))
				drop_q <= 1'b1;
		end

		if (i_halt_seen)
			halt_q <= 1'b1;
		// One free cycle after HALT leaves decode drains the older instructions
		if (halt_q && !i_stall)
			o_halted <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (issue)
		o_addr <= pc_q[XLEN-1:2];
	if (wait_q && i_rvalid) begin
		o_instr <= i_rdata;
		o_pc_next <= {o_addr + 1'b1, 2'b00};
	end
end

a_addr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
	o_req_valid && !i_ready |=> o_req_valid && $stable(o_addr));

endmodule

// File: hdl/core_decode.sv
`timescale 1ns/10ps

module core_decode import core_pkg::*; (
	input  logic             clk,
	input  logic             i_arst_n,
	input  instr_t           i_instr,
	input  logic             i_valid,
	input  logic [XLEN-1:0]  i_pc_next,
	input  logic             i_stall,
	input  logic             i_flush,
	input  logic [XLEN-1:0]  i_ra_val,
	input  logic [XLEN-1:0]  i_rb_val,
	input  logic [REG_W-1:0] i_ex_rd,
	input  logic             i_ex_wr,
	input  logic             i_ex_load,
	input  logic [XLEN-1:0]  i_ex_result,
	input  logic [REG_W-1:0] i_mem_rd,
	input  logic             i_mem_wr,
	input  logic [XLEN-1:0]  i_mem_result,
	output logic [REG_W-1:0] o_ra_sel,
	output logic [REG_W-1:0] o_rb_sel,
	output logic             o_hold,
	output logic             o_halt_seen,
	output op_e              o_op,
	output logic [REG_W-1:0] o_rd,
	output logic [XLEN-1:0]  o_opa,
	output logic [XLEN-1:0]  o_opb,
	output logic [XLEN-1:0]  o_imm,
	output logic [XLEN-1:0]  o_pc_next,
	output logic             o_valid
);

op_e             op;
logic            uses_a;
logic            uses_b;
logic            advance;
logic [XLEN-1:0] imm;

// The youngest producer wins, the register file only supplies settled values
function automatic logic [XLEN-1:0] operand(input logic [REG_W-1:0] sel,
		input logic [XLEN-1:0] rf_val);
	if (sel != '0 && i_ex_wr && i_ex_rd == sel)
		return i_ex_result;
	if (sel != '0 && i_mem_wr && i_mem_rd == sel)
		return i_mem_result;
	return rf_val;
endfunction

assign op = i_instr.r.opcode;
assign imm = {{(XLEN-20){i_instr.i.imm20[19]}}, i_instr.i.imm20};
assign o_ra_sel = i_instr.i.ra;

always_comb begin
	uses_a = 1'b1;
	uses_b = 1'b0;
	o_rb_sel = i_instr.r.rb;
	case (op)
		ADD, SUB, AND, OR, XOR, SLL, SRL: uses_b = 1'b1;
		ADDI, LDW: uses_b = 1'b0;
		STW, BEQ, BNE: begin
			uses_b = 1'b1;
			o_rb_sel = i_instr.i.rd;   // Second operand comes through rd
		end
		default: uses_a = 1'b0;
	endcase
end

// A load in execute has no data yet, so its consumer waits one cycle
assign o_hold = i_valid && i_ex_load && i_ex_rd != '0 &&
	((uses_a && o_ra_sel == i_ex_rd) || (uses_b && o_rb_sel == i_ex_rd));
assign advance = !i_stall && !o_hold;
assign o_halt_seen = i_valid && advance && !i_flush && op == HALT;

always_ff @(posedge clk or negedge i_arst_n) begin
	if (!i_arst_n)
		o_valid <= 1'b0;
	else if (!i_stall)
		o_valid <= i_valid && !o_hold && !i_flush;   // Hold leaves a bubble behind
end

always_ff @(posedge clk) begin
	if (advance) begin
		o_op <= op;
		o_rd <= i_instr.i.rd;
		o_opa <= operand(o_ra_sel, i_ra_val);
		o_opb <= operand(o_rb_sel, i_rb_val);
		o_imm <= imm;
		o_pc_next <= i_pc_next;
	end
end

endmodule

// File: hdl/core_execute.sv
`timescale 1ns/10ps

module core_execute import core_pkg::*; (
	input  logic             clk,
	input  logic             i_arst_n,
	input  op_e              i_op,
	input  logic [REG_W-1:0] i_rd,
	input  logic [XLEN-1:0]  i_opa,
	input  logic [XLEN-1:0]  i_opb,
	input  logic [XLEN-1:0]  i_imm,
	input  logic [XLEN-1:0]  i_pc_next,
	input  logic             i_valid,
	input  logic             i_stall,
	output logic             o_redirect,
	output logic [XLEN-1:0]  o_target,
	output logic [XLEN-1:0]  o_result,
	output logic [XLEN-1:0]  o_store_data,
	output logic [REG_W-1:0] o_rd,
	output logic             o_wr,
	output logic             o_load,
	output logic             o_store,
	output logic             o_valid,
	output logic             o_fwd_wr,
	output logic             o_fwd_load,
	output logic [XLEN-1:0]  o_fwd_result
);

logic [XLEN-1:0] alu;
logic            taken;
logic            writes;

always_comb begin
	case (i_op)
		ADD: alu = i_opa + i_opb;
		SUB: alu = i_opa - i_opb;
		AND: alu = i_opa & i_opb;
		OR: alu = i_opa | i_opb;
		XOR: alu = i_opa ^ i_opb;
		SLL: alu = i_opa << i_opb[$clog2(XLEN)-1:0];
		SRL: alu = i_opa >> i_opb[$clog2(XLEN)-1:0];
		ADDI, LDW, STW: alu = i_opa + i_imm;   // Memory ops produce the address
		default: alu = '0;
	endcase
end

assign writes = i_valid && i_rd != '0 &&
	(i_op inside {ADD, SUB, AND, OR, XOR, SLL, SRL, ADDI, LDW});
assign taken = i_valid &&
	((i_op == BEQ && i_opa == i_opb) || (i_op == BNE && i_opa != i_opb));

// Branch offsets count words from the next instruction
assign o_redirect = taken && !i_stall;
assign o_target = i_pc_next + {i_imm[XLEN-3:0], 2'b00};

// A load's address is never a register value
assign o_fwd_wr = writes && i_op != LDW;
assign o_fwd_load = i_valid && i_op == LDW;
assign o_fwd_result = alu;

always_ff @(posedge clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		o_valid <= 1'b0;
		o_wr <= 1'b0;
		o_load <= 1'b0;
		o_store <= 1'b0;
	end else if (!i_stall) begin
		o_valid <= i_valid && !taken;   // A taken branch is finished here
		o_wr <= writes;
		o_load <= i_valid && i_op == LDW;
		o_store <= i_valid && i_op == STW;
	end
end

always_ff @(posedge clk) begin
	if (!i_stall) begin
		o_result <= alu;
		o_store_data <= i_opb;
		o_rd <= i_rd;
	end
end

endmodule

// File: hdl/core_memory.sv
`timescale 1ns/10ps

module core_memory import core_pkg::*; (
	input  logic             clk,
	input  logic             i_arst_n,
	input  logic [XLEN-1:0]  i_result,
	input  logic [XLEN-1:0]  i_store_data,
	input  logic [REG_W-1:0] i_rd,
	input  logic             i_wr,
	input  logic             i_load,
	input  logic             i_store,
	input  logic             i_valid,
	input  logic             i_ready,
	input  logic             i_rvalid,
	input  logic [XLEN-1:0]  i_rdata,
	output logic             o_req_valid,
	output logic [XLEN-3:0]  o_addr,
	output logic             o_we,
	output logic [XLEN-1:0]  o_wdata,
	output logic             o_stall,
	output logic             o_wr_en,
	output logic [REG_W-1:0] o_wr_sel,
	output logic [XLEN-1:0]  o_wr_val
);

logic access;
logic wait_q;   // Request accepted, response pending

assign access = i_valid && (i_load || i_store);

assign o_req_valid = access && !wait_q;
assign o_addr = i_result[XLEN-1:2];
assign o_we = i_store;
assign o_wdata = i_store_data;

// The stage releases in the cycle the response comes back
assign o_stall = access && !(wait_q && i_rvalid);

assign o_wr_en = i_valid && i_wr && !o_stall;
assign o_wr_sel = i_rd;
assign o_wr_val = i_load ? i_rdata : i_result;

always_ff @(posedge clk or negedge i_arst_n) begin
	if (!i_arst_n)
		wait_q <= 1'b0;
	else if (o_req_valid && i_ready)
		wait_q <= 1'b1;
	else if (i_rvalid)
		wait_q <= 1'b0;
end

// Execute must keep the access stable while this stage waits
a_stall_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
	o_stall |=> ($stable(i_rd) && $stable(i_result) && $stable(i_store)));

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter import core_pkg::*; (
	input  logic            clk,
	input  logic            i_arst_n,
	input  logic            i_f_req_valid,
	input  logic [XLEN-3:0] i_f_addr,
	input  logic            i_f_we,
	input  logic [XLEN-1:0] i_f_wdata,
	output logic            o_f_ready,
	output logic            o_f_rvalid,
	input  logic            i_d_req_valid,
	input  logic [XLEN-3:0] i_d_addr,
	input  logic            i_d_we,
	input  logic [XLEN-1:0] i_d_wdata,
	output logic            o_d_ready,
	output logic            o_d_rvalid,
	output logic [XLEN-1:0] o_rdata,
	output logic            o_mem_valid,
	output logic [XLEN-3:0] o_mem_addr,
	output logic            o_mem_we,
	output logic [XLEN-1:0] o_mem_wdata,
	input  logic            i_mem_ready,
	input  logic            i_mem_rvalid,
	input  logic [XLEN-1:0] i_mem_rdata
);

logic busy_q;
logic owner_d_q;
logic pend_q;
logic pend_d_q;
logic pick_d;

// A request already shown to memory keeps the port until it is taken
assign pick_d = pend_q ? pend_d_q : i_d_req_valid;

assign o_mem_valid = !busy_q && (pick_d ? i_d_req_valid : i_f_req_valid);
assign o_mem_addr = pick_d ? i_d_addr : i_f_addr;
assign o_mem_we = pick_d ? i_d_we : i_f_we;
assign o_mem_wdata = pick_d ? i_d_wdata : i_f_wdata;

assign o_d_ready = o_mem_valid && pick_d && i_mem_ready;
assign o_f_ready = o_mem_valid && !pick_d && i_mem_ready;

assign o_d_rvalid = busy_q && owner_d_q && i_mem_rvalid;
assign o_f_rvalid = busy_q && !owner_d_q && i_mem_rvalid;
assign o_rdata = i_mem_rdata;

always_ff @(posedge clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		busy_q <= 1'b0;
		owner_d_q <= 1'b0;
		pend_q <= 1'b0;
		pend_d_q <= 1'b0;
	end else begin
		if (o_mem_valid) begin
			pend_q <= !i_mem_ready;
			pend_d_q <= pick_d;
		end
		if (o_mem_valid && i_mem_ready) begin
			busy_q <= 1'b1;
			owner_d_q <= pick_d;
		end else if (i_mem_rvalid) begin
			busy_q <= 1'b0;
		end
	end
end

a_rvalid_owned: assert property (@(posedge clk) disable iff (!i_arst_n)
	i_mem_rvalid |-> busy_q);

endmodule

// File: hdl/core_top.sv
`timescale 1ns/10ps

module core_top import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            i_arst_n,
	output logic            o_mem_valid,
	output logic [XLEN-3:0] o_mem_addr,
	output logic            o_mem_we,
	output logic [XLEN-1:0] o_mem_wdata,
	input  logic            i_mem_ready,
	input  logic            i_mem_rvalid,
	input  logic [XLEN-1:0] i_mem_rdata,
	output logic            o_halted
);

instr_t           fd_instr;
logic             fd_valid;
logic [XLEN-1:0]  fd_pc_next;
logic             f_req_valid;
logic [XLEN-3:0]  f_addr;
logic             f_ready;
logic             f_rvalid;
logic [XLEN-1:0]  bus_rdata;
logic             d_req_valid;
logic [XLEN-3:0]  d_addr;
logic             d_we;
logic [XLEN-1:0]  d_wdata;
logic             d_ready;
logic             d_rvalid;
logic             dec_hold;
logic             halt_seen;
logic [REG_W-1:0] ra_sel;
logic [REG_W-1:0] rb_sel;
logic [XLEN-1:0]  ra_val;
logic [XLEN-1:0]  rb_val;
op_e              de_op;
logic [REG_W-1:0] de_rd;
logic [XLEN-1:0]  de_opa;
logic [XLEN-1:0]  de_opb;
logic [XLEN-1:0]  de_imm;
logic [XLEN-1:0]  de_pc_next;
logic             de_valid;
logic             ef_redirect;
logic [XLEN-1:0]  ef_target;
logic             ex_fwd_wr;
logic             ex_fwd_load;
logic [XLEN-1:0]  ex_fwd_result;
logic [XLEN-1:0]  em_result;
logic [XLEN-1:0]  em_store_data;
logic [REG_W-1:0] em_rd;
logic             em_wr;
logic             em_load;
logic             em_store;
logic             em_valid;
logic             mem_stall;
logic             wb_en;
logic [REG_W-1:0] wb_sel;
logic [XLEN-1:0]  wb_val;
wire              fetch_stall = mem_stall | dec_hold;

core_fetch #(.RESET_PC(RESET_PC)) i_core_fetch (
	.clk(clk), .i_arst_n(i_arst_n), .i_stall(fetch_stall),
	.i_redirect(ef_redirect), .i_target(ef_target), .i_halt_seen(halt_seen),
	.i_ready(f_ready), .i_rvalid(f_rvalid), .i_rdata(bus_rdata),
	.o_req_valid(f_req_valid), .o_addr(f_addr), .o_instr(fd_instr),
	.o_pc_next(fd_pc_next), .o_valid(fd_valid), .o_halted(o_halted)
);

core_decode i_core_decode (
	.clk(clk), .i_arst_n(i_arst_n), .i_instr(fd_instr), .i_valid(fd_valid),
	.i_pc_next(fd_pc_next), .i_stall(mem_stall), .i_flush(ef_redirect),
	.i_ra_val(ra_val), .i_rb_val(rb_val),
	.i_ex_rd(de_rd), .i_ex_wr(ex_fwd_wr), .i_ex_load(ex_fwd_load),
	.i_ex_result(ex_fwd_result), .i_mem_rd(wb_sel), .i_mem_wr(wb_en),
	.i_mem_result(wb_val), .o_ra_sel(ra_sel), .o_rb_sel(rb_sel),
	.o_hold(dec_hold), .o_halt_seen(halt_seen), .o_op(de_op), .o_rd(de_rd),
	.o_opa(de_opa), .o_opb(de_opb), .o_imm(de_imm), .o_pc_next(de_pc_next),
	.o_valid(de_valid)
);

core_regfile i_core_regfile (
	.clk(clk), .i_arst_n(i_arst_n), .i_ra_sel(ra_sel), .i_rb_sel(rb_sel),
	.i_wr_en(wb_en), .i_wr_sel(wb_sel), .i_wr_val(wb_val),
	.o_ra(ra_val), .o_rb(rb_val)
);

core_execute i_core_execute (
	.clk(clk), .i_arst_n(i_arst_n), .i_op(de_op), .i_rd(de_rd),
	.i_opa(de_opa), .i_opb(de_opb), .i_imm(de_imm), .i_pc_next(de_pc_next),
	.i_valid(de_valid), .i_stall(mem_stall), .o_redirect(ef_redirect),
	.o_target(ef_target), .o_result(em_result), .o_store_data(em_store_data),
	.o_rd(em_rd), .o_wr(em_wr), .o_load(em_load), .o_store(em_store),
	.o_valid(em_valid), .o_fwd_wr(ex_fwd_wr), .o_fwd_load(ex_fwd_load),
	.o_fwd_result(ex_fwd_result)
);

core_memory i_core_memory (
	.clk(clk), .i_arst_n(i_arst_n), .i_result(em_result),
	.i_store_data(em_store_data), .i_rd(em_rd), .i_wr(em_wr), .i_load(em_load),
	.i_store(em_store), .i_valid(em_valid), .i_ready(d_ready),
	.i_rvalid(d_rvalid), .i_rdata(bus_rdata), .o_req_valid(d_req_valid),
	.o_addr(d_addr), .o_we(d_we), .o_wdata(d_wdata), .o_stall(mem_stall),
	.o_wr_en(wb_en), .o_wr_sel(wb_sel), .o_wr_val(wb_val)
);

// Fetch only ever reads
bus_arbiter i_bus_arbiter (
	.clk(clk), .i_arst_n(i_arst_n),
	.i_f_req_valid(f_req_valid), .i_f_addr(f_addr), .i_f_we(1'b0),
	.i_f_wdata('0), .o_f_ready(f_ready), .o_f_rvalid(f_rvalid),
	.i_d_req_valid(d_req_valid), .i_d_addr(d_addr), .i_d_we(d_we),
	.i_d_wdata(d_wdata), .o_d_ready(d_ready), .o_d_rvalid(d_rvalid),
	.o_rdata(bus_rdata), .o_mem_valid(o_mem_valid), .o_mem_addr(o_mem_addr),
	.o_mem_we(o_mem_we), .o_mem_wdata(o_mem_wdata), .i_mem_ready(i_mem_ready),
	.i_mem_rvalid(i_mem_rvalid), .i_mem_rdata(i_mem_rdata)
);

endmodule

// File: verification/core_tb_mem.sv
`timescale 1ns/10ps

module core_tb_mem #(
	parameter int DEPTH = 1024
) (
	input  logic        clk,
	input  logic        i_arst_n,
	input  logic        i_valid,
	input  logic [29:0] i_addr,
	input  logic        i_we,
	input  logic [31:0] i_wdata,
	input  logic        i_rand_ready,
	input  logic [1:0]  i_rand_lat,
	output logic        o_ready,
	output logic        o_rvalid,
	output logic [31:0] o_rdata
);

localparam int AW = $clog2(DEPTH);

logic [31:0] mem [DEPTH];
logic        ready_q = 1'b0;
logic        rvalid_q = 1'b0;
logic [31:0] rdata_q = '0;
logic [31:0] read_word = '0;
logic        accepted = 1'b0;
logic        busy = 1'b0;
logic [1:0]  wait_cnt = '0;

assign o_ready = ready_q;
assign o_rvalid = rvalid_q;
assign o_rdata = rdata_q;

task automatic load_word(input int addr, input logic [31:0] data);
	mem[addr] = data;
endtask

// The handshake itself is taken on the rising edge
always @(posedge clk) begin
	accepted <= i_valid && ready_q;
	if (i_valid && ready_q) begin
		if (i_we)
			mem[i_addr[AW-1:0]] <= i_wdata;
		else
			read_word <= mem[i_addr[AW-1:0]];
	end
end

always @(negedge clk) begin
	ready_q <= 1'b0;
	rvalid_q <= 1'b0;
	if (!i_arst_n) begin
		busy <= 1'b0;
		wait_cnt <= '0;
	end else if (accepted) begin
		busy <= 1'b1;
		wait_cnt <= i_rand_lat;   // Extra cycles before the response
	end else if (busy) begin
		if (wait_cnt == '0) begin
			rvalid_q <= 1'b1;
			rdata_q <= read_word;
			busy <= 1'b0;
		end else begin
			wait_cnt <= wait_cnt - 2'd1;
		end
	end else if (!rvalid_q) begin
		ready_q <= i_rand_ready;
	end
end

endmodule

// File: verification/core_tb.sv
`timescale 1ns/10ps

module core_tb import core_pkg::*; ();

localparam logic [31:0] RESET_PC = 32'h100;
localparam int N = 16;
localparam int NUM_INSTR = 4 * N + 6;
localparam int TIMEOUT = NUM_INSTR * 40;
localparam int DATA_B = 32'h800;   // Operand pairs, two words per table entry
localparam int RES_B = 32'hC00;
localparam int MARK_B = 32'hE00;

logic        clk = 1'b0;
logic        i_arst_n = 1'b0;
logic        o_mem_valid;
logic [29:0] o_mem_addr;
logic        o_mem_we;
logic [31:0] o_mem_wdata;
logic        i_mem_ready;
logic        i_mem_rvalid;
logic [31:0] i_mem_rdata;
logic        o_halted;
logic        rand_ready = 1'b0;
logic [1:0]  rand_lat = '0;
logic [31:0] lfsr_state = 32'd4;
logic        halt_flag = 1'b0;
int          cycles = 0;
int          prog_w;

op_e         tab_op [N];
logic [31:0] tab_a [N];
logic [31:0] tab_b [N];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];

always #4 clk = ~clk;

core_top #(.RESET_PC(RESET_PC)) i_core_top (
	.clk(clk), .i_arst_n(i_arst_n), .o_mem_valid(o_mem_valid),
	.o_mem_addr(o_mem_addr), .o_mem_we(o_mem_we), .o_mem_wdata(o_mem_wdata),
	.i_mem_ready(i_mem_ready), .i_mem_rvalid(i_mem_rvalid),
	.i_mem_rdata(i_mem_rdata), .o_halted(o_halted)
);

core_tb_mem i_core_tb_mem (
	.clk(clk), .i_arst_n(i_arst_n), .i_valid(o_mem_valid), .i_addr(o_mem_addr),
	.i_we(o_mem_we), .i_wdata(o_mem_wdata), .i_rand_ready(rand_ready),
	.i_rand_lat(rand_lat), .o_ready(i_mem_ready), .o_rvalid(i_mem_rvalid),
	.o_rdata(i_mem_rdata)
);

// Taps 32, 22, 2 and 1
function automatic logic lfsr_bit();
	lfsr_state = {lfsr_state[30:0],
		lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
	return lfsr_state[0];
endfunction

function automatic logic [31:0] random_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++)
		v = {v[30:0], lfsr_bit()};
	return v;
endfunction

function automatic op_e op_for(input int i);
	case (i % 8)
		0: return ADD;
		1: return SUB;
		2: return AND;
		3: return OR;
		4: return XOR;
		5: return SLL;
		6: return SRL;
		default: return ADDI;
	endcase
endfunction

// ADDI takes the low 20 bits of operand B as its immediate
function automatic logic [31:0] alu_rule(input op_e op, input logic [31:0] a,
		input logic [31:0] b);
	case (op)
		ADD: return a + b;
		SUB: return a - b;
		AND: return a & b;
		OR: return a | b;
		XOR: return a ^ b;
		SLL: return a << b[4:0];
		SRL: return a >> b[4:0];
		default: return a + {{12{b[19]}}, b[19:0]};
	endcase
endfunction

function automatic logic [31:0] r_word(input op_e op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [3:0] rb);
	return {op, rd, ra, rb, 16'h0000};
endfunction

function automatic logic [31:0] i_word(input op_e op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [19:0] imm);
	return {op, rd, ra, imm};
endfunction

task automatic emit(input logic [31:0] word);
	i_core_tb_mem.load_word(prog_w, word);
	prog_w++;
endtask

task automatic fail_run(input string why);
	$display("%s", why);
	$display("Finished with errors");
	$fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp)
		fail_run($sformatf("[ERROR] %0d ns: %s is 0x%08h, expected 0x%08h",
			$time, name, got, exp));
endtask

always @(negedge clk) begin
	rand_ready <= lfsr_bit();
	rand_lat <= 2'(random_bits(2));
end

always @(posedge clk) begin
	if (i_arst_n) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT)
			fail_run("Timeout, the core did not halt within the cycle limit");
	end
end

always @(posedge clk) begin
	if (i_arst_n) begin
		if (halt_flag && o_mem_valid)
			fail_run("The core made a memory request after it halted");
		if (halt_flag && !o_halted)
			fail_run("o_halted went low again after it had risen");
		if (o_mem_valid && i_mem_ready && o_mem_we) begin
			if (o_mem_addr == 30'(MARK_B / 4))
				fail_run("The store behind the taken BEQ reached the bus");
			else if (exp_addr.size() == 0)
				fail_run("The core stored more words than the program holds");
			else begin
				check_value("o_mem_addr", 32'(o_mem_addr), exp_addr.pop_front());
				check_value("o_mem_wdata", o_mem_wdata, exp_data.pop_front());
			end
		end
	end
end

initial begin
	logic [31:0] res;
	res = '0;
	// Stray fetches land on HALT words that still carry their address
	for (int a = 0; a < 1024; a++)
		i_core_tb_mem.load_word(a, {HALT, 28'(a)});
	for (int i = 0; i < N; i++) begin
		tab_op[i] = op_for(i);
		tab_a[i] = random_bits(32);
		tab_b[i] = random_bits(32);
		if (tab_op[i] == ADDI)
			tab_b[i][19] = (i >= N / 2);   // One positive and one negative immediate
	end

	prog_w = int'(RESET_PC >> 2);
	for (int i = 0; i < N; i++) begin
		res = alu_rule(tab_op[i], tab_a[i], tab_b[i]);
		i_core_tb_mem.load_word(DATA_B / 4 + 2 * i, tab_a[i]);
		i_core_tb_mem.load_word(DATA_B / 4 + 2 * i + 1, tab_b[i]);
		emit(i_word(LDW, 4'd1, 4'd0, 20'(DATA_B + 8 * i)));
		emit(i_word(LDW, 4'd2, 4'd0, 20'(DATA_B + 8 * i + 4)));
		if (tab_op[i] == ADDI)
			emit(i_word(ADDI, 4'd3, 4'd1, tab_b[i][19:0]));
		else
			emit(r_word(tab_op[i], 4'd3, 4'd1, 4'd2));   // Uses r2 right after its load
		emit(i_word(STW, 4'd3, 4'd0, 20'(RES_B + 4 * i)));
		exp_addr.push_back(32'(RES_B / 4 + i));
		exp_data.push_back(res);
	end
	emit(i_word(BEQ, 4'd0, 4'd0, 20'd1));
	emit(i_word(STW, 4'd1, 4'd0, 20'(MARK_B)));
	emit(i_word(BNE, 4'd3, 4'd3, 20'd1));   // Equal operands so it falls through
	emit(i_word(STW, 4'd3, 4'd0, 20'(RES_B + 4 * N)));
	emit(i_word(NOP, 4'd0, 4'd0, 20'd0));
	emit(i_word(HALT, 4'd0, 4'd0, 20'd0));
	exp_addr.push_back(32'(RES_B / 4 + N));
	exp_data.push_back(res);

	repeat (5) @(negedge clk);
	check_value("o_mem_valid", 32'(o_mem_valid), 32'd0);
	check_value("o_halted", 32'(o_halted), 32'd0);
	i_arst_n <= 1'b1;

	while (o_halted !== 1'b1)
		@(negedge clk);
	check_value("stores_left", 32'(exp_addr.size()), 32'd0);
	halt_flag = 1'b1;
	repeat (20) @(negedge clk);

	$display("Finished with no errors");
	$finish;
end

endmodule

// File: filelist.f
hdl/core_pkg.sv
hdl/core_regfile.sv
hdl/core_fetch.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_memory.sv
hdl/bus_arbiter.sv
hdl/core_top.sv
verification/core_tb_mem.sv
verification/core_tb.sv
